//--- exec_unit.f
rtl/exec_pkg.sv
rtl/int_alu.sv
rtl/iter_mul.sv
rtl/iter_div.sv
rtl/exec_unit.sv
bench/exec_unit_tb.sv

//--- Bender.yml
package:
  name: exec_unit

sources:
  - rtl/exec_pkg.sv
  - rtl/int_alu.sv
  - rtl/iter_mul.sv
  - rtl/iter_div.sv
  - rtl/exec_unit.sv
  - target: simulation
    files:
      - bench/exec_unit_tb.sv

//--- bench/exec_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module exec_unit_tb;
    import exec_pkg::*;

    localparam int XLEN      = 64;
    localparam int N_SINGLE  = 300;
    localparam int N_MUL     = 24;
    localparam int N_DIV     = 48;
    localparam int TOTAL_OPS = N_SINGLE + N_MUL + N_DIV + 8 + 4;
    localparam logic [XLEN-1:0] MIN_NEG = {1'b1, {(XLEN-1){1'b0}}};

    logic            clk;
    logic            rst_n;
    logic            issue;
    logic            flush;
    exec_ctrl_t      ctrl;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] csr;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] res;
    logic            busy;
    logic            done;

    // expected state of the operation in flight
    logic [XLEN-1:0] exp_res = '0;
    int unsigned     exp_lat = 0;
    int unsigned     issue_cyc = 0;
    int unsigned     cycle = 0;
    int unsigned     offset;
    bit              pending = 0;
    bit              started = 0;
    bit              in_multi;
    int              errors = 0;
    int              pass_cnt = 0;
    int              fail_cnt = 0;

    exec_unit #(.XLEN(XLEN)) dut0 (
        .clk(clk), .rst_n(rst_n), .issue(issue), .flush(flush), .ctrl(ctrl),
        .pc(pc), .rs1(rs1), .rs2(rs2), .csr(csr), .imm(imm),
        .res(res), .busy(busy), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    assign offset   = cycle - issue_cyc;
    assign in_multi = pending && (exp_lat > 1) && (offset < exp_lat);

    chk_res: assert property (@(posedge clk) disable iff (!rst_n) done |-> res == exp_res)
        else begin
            errors++;
            $display("Error at %0t: res got %h expected %h", $time, $sampled(res), exp_res);
        end
    chk_owned: assert property (@(posedge clk) disable iff (!rst_n) done |-> pending)
        else begin
            errors++;
            $display("done pulse with no operation outstanding at %0t", $time);
        end
    chk_lat: assert property (@(posedge clk) disable iff (!rst_n)
        done && pending |-> offset == exp_lat)
        else begin
            errors++;
            $display("Error at %0t: done latency got %0d expected %0d",
                     $time, $sampled(offset), exp_lat);
        end
    chk_busy_hold: assert property (@(posedge clk) disable iff (!rst_n)
        in_multi && offset >= 1 |-> busy)
        else begin
            errors++;
            $display("Error at %0t: busy got 0 expected 1", $time);
        end
    // flush in the sampled cycle still sees the old busy level
    chk_busy_idle: assert property (@(posedge clk) disable iff (!rst_n) busy |-> in_multi || flush)
        else begin
            errors++;
            $display("Error at %0t: busy got 1 expected 0", $time);
        end
    chk_flush: assert property (@(posedge clk) disable iff (!rst_n) flush |=> !busy && !done)
        else begin
            errors++;
            $display("busy or done still high after flush at %0t", $time);
        end
    chk_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !busy && !done && res == '0)
        else begin
            errors++;
            $display("outputs not idle after reset at %0t", $time);
        end

    // RISC-V division, including divide by zero and signed overflow
    function automatic logic [XLEN-1:0] div_ref(alu_op_e op, logic [XLEN-1:0] a,
                                                logic [XLEN-1:0] b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic signed [XLEN-1:0] q;
        logic signed [XLEN-1:0] r;
        logic                   ovf;
        sa  = a;
        sb  = b;
        ovf = (a == MIN_NEG) && (b == '1);
        case (op)
            OP_DIVU: return (b == '0) ? '1 : a / b;
            OP_REMU: return (b == '0) ? a : a % b;
            default: begin
                if (b == '0) begin
                    return (op == OP_DIV) ? '1 : a;
                end
                if (ovf) begin
                    return (op == OP_DIV) ? MIN_NEG : '0;
                end
                // truncating signed quotient and remainder
                q = sa / sb;
                r = sa % sb;
                return (op == OP_DIV) ? q : r;
            end
        endcase
    endfunction

    function automatic logic [XLEN-1:0] model(alu_op_e op, logic word, logic [XLEN-1:0] a,
                                              logic [XLEN-1:0] b);
        logic [XLEN-1:0] sx;
        sx = $signed({{(XLEN-32){a[31]}}, a[31:0]}) >>> b[5:0];
        case (op)
            OP_ADD:    return a + b;
            OP_SUB:    return a - b;
            OP_PASS_A: return a;
            OP_PASS_B: return b;
            OP_XOR:    return a ^ b;
            OP_OR:     return a | b;
            OP_AND:    return a & b;
            OP_SLL:    return a << b[5:0];
            OP_SRL:    return a >> b[5:0];
            OP_SRA: begin
                if (word) begin
                    return {{(XLEN-32){1'b0}}, sx[31:0]};
                end
                return $signed(a) >>> b[5:0];
            end
            OP_SLT:    return XLEN'($signed(a) < $signed(b));
            OP_SLTU:   return XLEN'(a < b);
            OP_EQ:     return XLEN'(a == b);
            OP_GE:     return XLEN'($signed(a) >= $signed(b));
            OP_GEU:    return XLEN'(a >= b);
            OP_MUL:    return a * b;
            default:   return div_ref(op, a, b);
        endcase
    endfunction

    // cycles from the issue sample to the sampled done pulse
    function automatic int unsigned latency_of(alu_op_e op);
        if (op == OP_MUL) return XLEN + 2;
        if (op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU}) return XLEN + 3;
        return 1;
    endfunction

    function automatic exec_ctrl_t make_ctrl(alu_op_e op, src_a_e sa, src_b_e sb, logic w);
        exec_ctrl_t c;
        c.op    = op;
        c.sel_a = sa;
        c.sel_b = sb;
        c.word  = w;
        return c;
    endfunction

    // mix of full-width, narrow and narrow negative values
    function automatic logic [XLEN-1:0] rand_val();
        logic [XLEN-1:0] v;
        v = {$urandom, $urandom};
        if ($urandom_range(1)) v = v >> $urandom_range(XLEN - 1);
        if ($urandom_range(3) == 0) v = -v;
        return v;
    endfunction

    task automatic drive_issue(exec_ctrl_t c, logic [XLEN-1:0] pc_v, logic [XLEN-1:0] rs1_v,
                               logic [XLEN-1:0] rs2_v, logic [XLEN-1:0] csr_v,
                               logic [XLEN-1:0] imm_v);
        logic [XLEN-1:0] a_v;
        logic [XLEN-1:0] b_v;
        a_v = (c.sel_a == SRC_A_PC) ? pc_v : (c.word ? XLEN'(rs1_v[31:0]) : rs1_v);
        b_v = (c.sel_b == SRC_B_RS2) ? rs2_v : ((c.sel_b == SRC_B_CSR) ? csr_v : imm_v);
        exp_res   = model(c.op, c.word, a_v, b_v);
        exp_lat   = latency_of(c.op);
        issue_cyc = cycle;
        pending   = 1'b1;
        started   = 1'b1;
        ctrl = c;
        pc   = pc_v;
        rs1  = rs1_v;
        rs2  = rs2_v;
        csr  = csr_v;
        imm  = imm_v;
        issue = 1'b1;
        @(posedge clk);
        #1 issue = 1'b0;
    endtask

    task automatic run_op(exec_ctrl_t c, logic [XLEN-1:0] pc_v, logic [XLEN-1:0] rs1_v,
                          logic [XLEN-1:0] rs2_v, logic [XLEN-1:0] csr_v,
                          logic [XLEN-1:0] imm_v);
        int n;
        n = 0;
        drive_issue(c, pc_v, rs1_v, rs2_v, csr_v, imm_v);
        while (!done && n < XLEN + 10) begin
            @(posedge clk);
            #1 n++;
        end
        if (!done) begin
            errors++;
            $display("no done for %s issued at cycle %0d", c.op.name(), issue_cyc);
        end
        // keep the op pending until the done pulse has been sampled
        @(posedge clk);
        #1 pending = 1'b0;
    endtask

    task automatic run_random(alu_op_e op);
        exec_ctrl_t c;
        c = make_ctrl(op, src_a_e'($urandom_range(1)), src_b_e'($urandom_range(2)),
                      1'($urandom_range(1)));
        run_op(c, rand_val(), rand_val(), rand_val(), rand_val(), rand_val());
    endtask

    task automatic flush_then_run(alu_op_e op);
        exec_ctrl_t      c;
        logic [XLEN-1:0] x;
        logic [XLEN-1:0] y;
        c = make_ctrl(op, SRC_A_RS1, SRC_B_RS2, 1'b0);
        x = rand_val();
        y = rand_val();
        drive_issue(c, '0, x, y, '0, '0);
        repeat ($urandom_range(40, 5)) @(posedge clk);
        #1 flush = 1'b1;
        pending = 1'b0;
        @(posedge clk);
        #1 flush = 1'b0;
        // any late done from the cancelled op trips chk_owned
        repeat (XLEN + 8) @(posedge clk);
        #1 run_op(c, '0, x, y, '0, '0);
    endtask

    task automatic report_test(string name, int err_before);
        if (errors == err_before) begin
            pass_cnt++;
            $display("test %-8s ok", name);
        end else begin
            fail_cnt++;
            $display("test %-8s FAILED with %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        int e0;
        void'($urandom(32'h2470));
        rst_n = 1'b0;
        issue = 1'b0;
        flush = 1'b0;
        ctrl  = '0;
        {pc, rs1, rs2, csr, imm} = '0;
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        e0 = errors;
        repeat (10) @(posedge clk);
        #1 report_test("reset", e0);
        e0 = errors;
        repeat (N_SINGLE) run_random(alu_op_e'($urandom_range(14)));
        report_test("single", e0);
        e0 = errors;
        repeat (N_MUL) run_random(OP_MUL);
        report_test("mul", e0);
        e0 = errors;
        for (int i = 0; i < N_DIV; i++) run_random(alu_op_e'(int'(OP_DIV) + i % 4));
        report_test("div", e0);
        // divide by zero and most negative over minus one
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            run_op(make_ctrl(alu_op_e'(int'(OP_DIV) + i), SRC_A_RS1, SRC_B_RS2, 1'b0),
                   '0, rand_val(), '0, '0, '0);
            run_op(make_ctrl(alu_op_e'(int'(OP_DIV) + i), SRC_A_RS1, SRC_B_IMM, 1'b0),
                   '0, MIN_NEG, '0, '0, '1);
        end
        report_test("corner", e0);
        e0 = errors;
        flush_then_run(OP_MUL);
        flush_then_run(OP_REM);
        report_test("flush", e0);
        $display("summary: %0d tests passed, %0d tests failed, %0d check errors",
                 pass_cnt, fail_cnt, errors);
        if (fail_cnt == 0 && errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    // about 70 cycles per operation plus slack for reset and flush waits
    initial begin
        #((TOTAL_OPS * 70 + 1000) * 10);
        $display("watchdog expired before the tests finished");
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/exec_unit.sv
`timescale 1ns/10ps
`default_nettype none

module exec_unit #(
    parameter int XLEN = 64
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 issue,
    input  logic                 flush,
    input  exec_pkg::exec_ctrl_t ctrl,
    input  logic [XLEN-1:0]      pc,
    input  logic [XLEN-1:0]      rs1,
    input  logic [XLEN-1:0]      rs2,
    input  logic [XLEN-1:0]      csr,
    input  logic [XLEN-1:0]      imm,
    output logic [XLEN-1:0]      res,
    output logic                 busy,
    output logic                 done
);
    import exec_pkg::*;

    logic [XLEN-1:0] rs1_in;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] alu_res;
    logic [XLEN-1:0] mul_res;
    logic [XLEN-1:0] div_res;
    logic            is_mul;
    logic            is_div;
    logic            mul_start;
    logic            div_start;
    logic            mul_done;
    logic            div_done;

    // operand select
    assign rs1_in = ctrl.word ? {{(XLEN-32){1'b0}}, rs1[31:0]} : rs1;
    assign a      = (ctrl.sel_a == SRC_A_RS1) ? rs1_in : pc;

    always_comb begin
        case (ctrl.sel_b)
            SRC_B_RS2: b = rs2;
            SRC_B_CSR: b = csr;
            default:   b = imm;
        endcase
    end

    assign is_mul    = ctrl.op == OP_MUL;
    assign is_div    = ctrl.op inside {OP_DIV, OP_DIVU, OP_REM, OP_REMU};
    assign mul_start = issue && is_mul;
    assign div_start = issue && is_div;

    int_alu #(.XLEN(XLEN)) u_alu (
        .op   (ctrl.op),
        .word (ctrl.word),
        .a    (a),
        .b    (b),
        .res  (alu_res)
    );

    iter_mul #(.XLEN(XLEN)) u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .start (mul_start),
        .flush (flush),
        .a     (a),
        .b     (b),
        .res   (mul_res),
        .done  (mul_done)
    );

    iter_div #(.XLEN(XLEN)) u_div (
        .clk   (clk),
        .rst_n (rst_n),
        .start (div_start),
        .flush (flush),
        .op    (ctrl.op),
        .a     (a),
        .b     (b),
        .res   (div_res),
        .done  (div_done)
    );

    // result register, busy level and done pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res  <= '0;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (flush) begin
                // drop whatever is in flight, unit done included
                busy <= 1'b0;
            end else if (issue) begin
                if (is_mul || is_div) begin
                    busy <= 1'b1;
                end else begin
                    res  <= alu_res;
                    done <= 1'b1;
                end
            end else if (busy && (mul_done || div_done)) begin
                res  <= mul_done ? mul_res : div_res;
                done <= 1'b1;
                busy <= 1'b0;
            end
        end
    end

    a_issue_idle: assert property (@(posedge clk) disable iff (!rst_n) issue |-> !busy)
        else $error("issue while busy");

    // flush and done never share a cycle
    a_flush_no_done: assert property (@(posedge clk) disable iff (!rst_n) flush |-> !done)
        else $error("done while flush");

endmodule

`default_nettype wire

//--- rtl/iter_div.sv
`timescale 1ns/10ps
`default_nettype none

module iter_div #(
    parameter int XLEN = 64
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  logic              flush,
    input  exec_pkg::alu_op_e op,
    input  logic [XLEN-1:0]   a,
    input  logic [XLEN-1:0]   b,
    output logic [XLEN-1:0]   res,
    output logic              done
);
    import exec_pkg::*;

    localparam int CW = $clog2(XLEN);

    logic            run;
    logic            fix;
    logic [CW-1:0]   cnt;
    logic            sgn_op;
    logic            rem_op;
    // latched operand info
    logic [XLEN-1:0] dvd;
    logic [XLEN-1:0] dvs;
    logic            neg_q;
    logic            neg_r;
    logic            is_rem;
    logic            dz;
    // working remainder and quotient
    logic [XLEN-1:0] rem;
    logic [XLEN-1:0] quo;
    logic [XLEN:0]   sh;
    logic [XLEN:0]   diff;
    logic            ge;

    assign sgn_op = (op == OP_DIV) || (op == OP_REM);
    assign rem_op = (op == OP_REM) || (op == OP_REMU);

    // restoring step
    assign sh   = {rem, quo[XLEN-1]};
    assign diff = sh - {1'b0, dvs};
    assign ge   = sh >= {1'b0, dvs};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run  <= 1'b0;
            fix  <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (flush) begin
                run <= 1'b0;
                fix <= 1'b0;
            end else if (start) begin
                run <= 1'b1;
                cnt <= '0;
            end else if (run) begin
                cnt <= cnt + 1'b1;
                if (cnt == CW'(XLEN-1)) begin
                    run <= 1'b0;
                    fix <= 1'b1;
                end
            end else if (fix) begin
                fix  <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            // divide magnitudes, signs come back in the fix cycle
            dvd    <= a;
            quo    <= (sgn_op && a[XLEN-1]) ? -a : a;
            dvs    <= (sgn_op && b[XLEN-1]) ? -b : b;
            rem    <= '0;
            neg_q  <= sgn_op && (a[XLEN-1] ^ b[XLEN-1]);
            neg_r  <= sgn_op && a[XLEN-1];
            is_rem <= rem_op;
            dz     <= b == '0;
        end else if (run) begin
            rem <= ge ? diff[XLEN-1:0] : sh[XLEN-1:0];
            quo <= {quo[XLEN-2:0], ge};
        end else if (fix) begin
            if (dz) begin
                res <= is_rem ? dvd : '1;
            end else if (is_rem) begin
                res <= neg_r ? -rem : rem;
            end else begin
                res <= neg_q ? -quo : quo;
            end
        end
    end

    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
        start |-> !(run || fix))
        else $error("iter_div started while running");

endmodule

`default_nettype wire

//--- rtl/iter_mul.sv
`timescale 1ns/10ps
`default_nettype none

module iter_mul #(
    parameter int XLEN = 64
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  logic            flush,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] res,
    output logic            done
);
    localparam int CW = $clog2(XLEN);

    logic            run;
    logic [CW-1:0]   cnt;
    logic [XLEN-1:0] mcand;
    logic [XLEN-1:0] mplier;
    logic [XLEN-1:0] acc;

    // step counter and done pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run  <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (flush) begin
                run <= 1'b0;
            end else if (start) begin
                run <= 1'b1;
                cnt <= '0;
            end else if (run) begin
                cnt <= cnt + 1'b1;
                if (cnt == CW'(XLEN-1)) begin
                    run  <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // one multiplier bit per cycle
    always_ff @(posedge clk) begin
        if (start) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (run) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign res = acc;

    // a new operand pair would corrupt the running product
    a_no_restart: assert property (@(posedge clk) disable iff (!rst_n) start |-> !run)
        else $error("iter_mul started while running");

endmodule

`default_nettype wire

//--- rtl/int_alu.sv
`timescale 1ns/10ps
`default_nettype none

module int_alu #(
    parameter int XLEN = 64
) (
    input  exec_pkg::alu_op_e op,
    input  logic              word,
    input  logic [XLEN-1:0]   a,
    input  logic [XLEN-1:0]   b,
    output logic [XLEN-1:0]   res
);
    import exec_pkg::*;

    localparam int SHW = $clog2(XLEN);

    logic [SHW-1:0]  shamt;
    logic [31:0]     sra_w;
    logic [XLEN-1:0] sra_d;
    logic            lt_s;
    logic            lt_u;
    logic            eq;

    // compare outcome as a full-width 0 or 1
    function automatic logic [XLEN-1:0] to_word(input logic f);
        return {{(XLEN-1){1'b0}}, f};
    endfunction

    assign shamt = b[SHW-1:0];

    // 32-bit arithmetic shift for the word form
    assign sra_w = $signed(a[31:0]) >>> shamt;
    assign sra_d = $signed(a) >>> shamt;

    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;
    assign eq   = a == b;

    always_comb begin
        case (op)
            OP_ADD:    res = a + b;
            OP_SUB:    res = a - b;
            OP_PASS_A: res = a;
            OP_PASS_B: res = b;
            OP_XOR:    res = a ^ b;
            OP_OR:     res = a | b;
            OP_AND:    res = a & b;
            OP_SLL:    res = a << shamt;
            OP_SRL:    res = a >> shamt;
            OP_SRA: begin
                // word result is zero-extended, not sign-extended
                if (word) begin
                    res = {{(XLEN-32){1'b0}}, sra_w};
                end else begin
                    res = sra_d;
                end
            end
            OP_SLT:    res = to_word(lt_s);
            OP_SLTU:   res = to_word(lt_u);
            OP_EQ:     res = to_word(eq);
            OP_GE:     res = to_word(!lt_s);
            OP_GEU:    res = to_word(!lt_u);
            // mul and div belong to the iterative units
            default:   res = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/exec_pkg.sv
`default_nettype none

package exec_pkg;

    // operation codes seen by the execute stage
    typedef enum logic [4:0] {
        OP_ADD    = 5'd0,
        OP_SUB    = 5'd1,
        OP_PASS_A = 5'd2,
        OP_PASS_B = 5'd3,
        OP_XOR    = 5'd4,
        OP_OR     = 5'd5,
        OP_AND    = 5'd6,
        OP_SLL    = 5'd7,
        OP_SRL    = 5'd8,
        OP_SRA    = 5'd9,
        OP_SLT    = 5'd10,
        OP_SLTU   = 5'd11,
        OP_EQ     = 5'd12,
        OP_GE     = 5'd13,
        OP_GEU    = 5'd14,
        // multi-cycle codes below
        OP_MUL    = 5'd15,
        OP_DIV    = 5'd16,
        OP_DIVU   = 5'd17,
        OP_REM    = 5'd18,
        OP_REMU   = 5'd19
    } alu_op_e;

    // operand a comes from pc or rs1
    typedef enum logic {
        SRC_A_PC  = 1'b0,
        SRC_A_RS1 = 1'b1
    } src_a_e;

    // operand b source, encoding 3 unused
    typedef enum logic [1:0] {
        SRC_B_IMM = 2'd0,
        SRC_B_RS2 = 2'd1,
        SRC_B_CSR = 2'd2
    } src_b_e;

    // decoded control for one issued operation
    typedef struct packed {
        alu_op_e op;
        src_a_e  sel_a;
        src_b_e  sel_b;
        // low 32 bits of rs1, zero-extended
        logic    word;
    } exec_ctrl_t;

endpackage

`default_nettype wire
